/* files.f */
+incdir+rtl
rtl/approx_mul_pkg.sv
rtl/lor_adder.sv
rtl/mul4x4_split.sv
rtl/mul8x8_approx.sv
rtl/result_fifo.sv
rtl/approx_mul_top.sv
verif/tb_approx_mul.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the approximate multiplier testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ns \
    --top-module tb_approx_mul \
    --Mdir obj_dir \
    -o tb_approx_mul \
    -f files.f

./obj_dir/tb_approx_mul | tee "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished without failures"

/* verif/tb_approx_mul.sv */
`timescale 1ns/1ns
`include "approx_mul_config.svh"

module tb_approx_mul;

    import approx_mul_pkg::*;

    localparam int N_CORNER   = 89;   // 5x5 corner pairs plus 8x8 single-bit pairs
    localparam int N_RANDOM   = 200;
    localparam int N_BP_EXTRA = 12;

    // Worst case per test, doubled
    localparam int CYCLE_LIMIT = 2 * (10 + (N_CORNER + 10) + (8 + 10) + 4 * N_RANDOM
                                      + 4 * (`AM_FIFO_DEPTH + 2 + N_BP_EXTRA));

    localparam logic [7:0] CORNERS [5] = '{8'd0, 8'd1, 8'd255, 8'd15, 8'd240};

    typedef struct packed {
        logic [15:0]          product;
        logic [15:0]          exact;
        logic [`AM_TAG_W-1:0] tag;
        logic [31:0]          acc_cycle;
    } exp_t;

    logic     clk = 1'b0;
    logic     rst_n;
    mul_req_t req;
    logic     req_valid;
    logic     req_ready;
    mul_rsp_t rsp;
    logic     rsp_valid;
    logic     rsp_ready;

    exp_t                 exp_q [$];
    logic [`AM_TAG_W-1:0] next_tag;
    logic                 chk_latency;
    int                   cycles = 0;
    int                   err_count = 0;
    int                   n_ok = 0;
    int                   n_bad = 0;

    approx_mul_top i_approx_mul_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    always #5 clk = ~clk;

    // ############################################################
    // Reference model
    // ############################################################
    function automatic int lor_add(input int x, input int y, input int k);
        int low_mask;
        int hi;
        low_mask = (1 << k) - 1;
        hi = (x >> k) + (y >> k);   // No carry out of the OR part
        return (hi << k) | ((x | y) & low_mask);
    endfunction

    function automatic int mul4_split(input int a, input int b, input int split, input int out_k);
        int mask, ah, al, bh, bl;
        int hh, hl, lh, ll;
        int op_w, op_hi, op_cross, s;
        mask = (1 << split) - 1;
        ah = a >> split;
        al = a & mask;
        bh = b >> split;
        bl = b & mask;
        hh = ah * bh;
        hl = ah * bl;
        lh = al * bh;
        ll = al * bl;
        op_w = 8 - split;
        op_hi = (hh << split) | (ll >> split);
        op_cross = lor_add(hl, lh, 0) & ((1 << op_w) - 1);
        s = lor_add(op_hi, op_cross, out_k) & ((1 << op_w) - 1);
        return ((s << split) | (ll & mask)) & 255;
    endfunction

    function automatic logic [15:0] approx_ref(input logic [7:0] a, input logic [7:0] b);
        int ah, al, bh, bl;
        int hh, ll, hl, lh;
        int mid, fin;
        ah = int'(a[7:4]);
        al = int'(a[3:0]);
        bh = int'(b[7:4]);
        bl = int'(b[3:0]);
        hh = ah * bh;
        ll = al * bl;
        hl = mul4_split(ah, bl, `AM_HL_SPLIT, `AM_HL_OUT_K);
        lh = mul4_split(al, bh, `AM_LH_SPLIT, `AM_LH_OUT_K);
        mid = lor_add(hl, lh, `AM_TOP_MID_K);
        fin = lor_add((hh << 4) | (ll >> 4), mid, `AM_TOP_OUT_K) & 4095;
        return 16'((fin << 4) | (ll & 15));
    endfunction

    // ############################################################
    // Checking helpers
    // ############################################################
    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, exp_v, act_v);
            err_count++;
        end
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        if (err_count == errs_at_start) begin
            $display("[%0t ns] %s: ok", $time, name);
            n_ok++;
        end else begin
            $display("[%0t ns] %s: %0d errors", $time, name, err_count - errs_at_start);
            n_bad++;
        end
    endtask

    // Scoreboard, cycle counter and run limit
    always @(posedge clk) begin : monitor
        exp_t e;
        if (rst_n) begin
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected response at %0t ns with no request outstanding",
                             $time);
                    err_count++;
                end else begin
                    e = exp_q.pop_front();
                    check_val("rsp.product", 32'(e.product), 32'(rsp.product));
                    check_val("rsp.tag", 32'(e.tag), 32'(rsp.tag));
                    check_val("rsp.product <= a*b", 1, 32'(rsp.product <= e.exact));
                    if (e.exact == '0) begin
                        check_val("rsp.product for zero operand", 0, 32'(rsp.product));
                    end
                    if (chk_latency) begin
                        check_val("response latency", 3, cycles - e.acc_cycle);
                    end
                end
            end
            if (req_valid && req_ready) begin
                e.product   = approx_ref(req.a, req.b);
                e.exact     = 16'(req.a) * 16'(req.b);
                e.tag       = req.tag;
                e.acc_cycle = cycles;
                exp_q.push_back(e);
            end
        end
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    // ############################################################
    // Stimulus helpers
    // ############################################################
    task automatic drive_req(input logic [7:0] a, input logic [7:0] b);
        req.a     = a;
        req.b     = b;
        req.tag   = next_tag;
        req_valid = 1'b1;
    endtask

    // Returns on the edge where the request is taken
    task automatic send_req(input logic [7:0] a, input logic [7:0] b);
        @(negedge clk);
        drive_req(a, b);
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        next_tag = next_tag + 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    task automatic wait_drained();
        idle_cycles(1);
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    // ############################################################
    // Tests
    // ############################################################
    task automatic reset_behavior();
        int errs;
        errs = err_count;
        repeat (4) begin
            @(negedge clk);
            check_val("rsp_valid", 0, 32'(rsp_valid));
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_val("rsp_valid", 0, 32'(rsp_valid));
        check_val("req_ready", 1, 32'(req_ready));
        end_test("reset", errs);
    endtask

    task automatic corner_operands();
        int errs;
        int i;
        int j;
        errs = err_count;
        for (i = 0; i < 5; i++) begin
            for (j = 0; j < 5; j++) begin
                send_req(CORNERS[i], CORNERS[j]);
            end
        end
        for (i = 0; i < 8; i++) begin
            for (j = 0; j < 8; j++) begin
                send_req(8'(1 << i), 8'(1 << j));
            end
        end
        wait_drained();
        end_test("directed corners", errs);
    endtask

    task automatic latency_throughput();
        int errs;
        int i;
        int prev_acc;
        errs = err_count;
        prev_acc = 0;
        chk_latency = 1'b1;
        for (i = 0; i < 8; i++) begin
            send_req(8'($urandom), 8'($urandom));
            if (i > 0) begin
                check_val("req accept spacing", 1, cycles - prev_acc);
            end
            prev_acc = cycles;
        end
        wait_drained();
        chk_latency = 1'b0;
        end_test("latency and throughput", errs);
    endtask

    task automatic random_stream();
        int errs;
        int n;
        int gap;
        errs = err_count;
        for (n = 0; n < N_RANDOM; n++) begin
            gap = $urandom % 4;
            if (gap != 0) begin
                idle_cycles(gap);
            end
            send_req(8'($urandom), 8'($urandom));
        end
        wait_drained();
        end_test("random stream", errs);
    endtask

    task automatic backpressure_order();
        int   errs;
        int   filled;
        int   remaining;
        logic pending;
        errs = err_count;
        filled = 0;
        remaining = N_BP_EXTRA;
        pending = 1'b0;
        rsp_ready = 1'b0;   // FIFO fills, then the pipeline stalls
        while (!pending) begin
            drive_req(8'($urandom), 8'($urandom));
            @(posedge clk);
            if (req_ready) begin
                filled++;
                next_tag = next_tag + 1'b1;
                @(negedge clk);
            end else begin
                pending = 1'b1;   // Payload held until taken
            end
        end
        check_val("requests accepted before req_ready fell", `AM_FIFO_DEPTH + 2, filled);
        check_val("rsp_valid", 1, 32'(rsp_valid));

        while (pending || remaining > 0) begin
            @(negedge clk);
            rsp_ready = ($urandom % 2) != 0;
            if (!pending) begin
                drive_req(8'($urandom), 8'($urandom));
                pending = 1'b1;
                remaining--;
            end
            @(posedge clk);
            if (req_ready) begin
                pending = 1'b0;
                next_tag = next_tag + 1'b1;
            end
        end

        @(negedge clk);
        req_valid = 1'b0;
        while (exp_q.size() != 0) begin
            rsp_ready = ($urandom % 2) != 0;
            @(negedge clk);
        end
        rsp_ready = 1'b1;
        end_test("back-pressure", errs);
    endtask

    initial begin
        void'($urandom(32'h6a49_ebec));
        rst_n       = 1'b0;
        req         = '0;
        req_valid   = 1'b0;
        rsp_ready   = 1'b1;
        next_tag    = '0;
        chk_latency = 1'b0;

        reset_behavior();
        corner_operands();
        latency_throughput();
        random_stream();
        backpressure_order();

        $display("Summary: %0d tests ok, %0d tests with errors, %0d errors in total",
                 n_ok, n_bad, err_count);
        if (err_count == 0 && n_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* rtl/approx_mul_top.sv */
`timescale 1ns/1ns
`include "approx_mul_config.svh"

module approx_mul_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  approx_mul_pkg::mul_req_t req,
    input  logic                     req_valid,
    output logic                     req_ready,
    output approx_mul_pkg::mul_rsp_t rsp,
    output logic                     rsp_valid,
    input  logic                     rsp_ready
);

    import approx_mul_pkg::*;

    mul_rsp_t mul_out;        // Pipeline result into the FIFO
    logic     mul_out_valid;
    logic     mul_out_ready;

    mul8x8_approx i_mul8x8_approx (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (req),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .out       (mul_out),
        .out_valid (mul_out_valid),
        .out_ready (mul_out_ready)
    );

    result_fifo #(
        .DEPTH (`AM_FIFO_DEPTH)
    ) i_result_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (mul_out),
        .in_valid  (mul_out_valid),
        .in_ready  (mul_out_ready),
        .out       (rsp),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready)
    );

endmodule

/* rtl/result_fifo.sv */
`timescale 1ns/1ns

module result_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  approx_mul_pkg::mul_rsp_t in,
    input  logic                     in_valid,
    output logic                     in_ready,
    output approx_mul_pkg::mul_rsp_t out,
    output logic                     out_valid,
    input  logic                     out_ready
);

    import approx_mul_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mul_rsp_t         mem [DEPTH];
    mul_rsp_t         head_next;
    logic [PTR_W-1:0] wr_ptr, rd_ptr, rd_ptr_next;
    logic [CNT_W-1:0] count, count_next;
    logic             push, pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready = (count != CNT_W'(DEPTH));
    assign push     = in_valid && in_ready;
    assign pop      = out_valid && out_ready;

    assign count_next  = count + CNT_W'(push) - CNT_W'(pop);
    assign rd_ptr_next = pop ? ptr_inc(rd_ptr) : rd_ptr;

    // Head comes straight from the input when nothing else remains
    assign head_next = (count == CNT_W'(pop)) ? in : mem[rd_ptr_next];

    // ############################################################
    // Pointers, count and output register
    // ############################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            rd_ptr    <= rd_ptr_next;
            count     <= count_next;
            out_valid <= (count_next != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in;
        end
        out <= head_next;
    end

    a_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(DEPTH))
        else $error("result_fifo count above DEPTH");

    // An empty FIFO without a write stays empty, so count never wraps below zero
    a_cnt_min: assert property (@(posedge clk) disable iff (!rst_n)
        (count == '0) && !push |=> (count == '0))
        else $error("result_fifo count below zero");

endmodule

/* rtl/mul8x8_approx.sv */
`timescale 1ns/1ns
`include "approx_mul_config.svh"

module mul8x8_approx (
    input  logic                     clk,
    input  logic                     rst_n,
    input  approx_mul_pkg::mul_req_t in,
    input  logic                     in_valid,
    output logic                     in_ready,
    output approx_mul_pkg::mul_rsp_t out,
    output logic                     out_valid,
    input  logic                     out_ready
);

    import approx_mul_pkg::*;

    logic [7:0]           pp_hh, pp_hl, pp_lh, pp_ll;

    logic                 s1_valid;
    logic [7:0]           s1_hh, s1_hl, s1_lh, s1_ll;
    logic [`AM_TAG_W-1:0] s1_tag;

    logic                 s1_adv;
    logic                 s2_adv;

    logic [8:0]           mid_sum;
    logic [11:0]          fin_x, fin_y;
    logic [12:0]          fin_sum;
    mul_rsp_t             s2_next;

    // ############################################################
    // Nibble products, ahead of stage 1
    // ############################################################
    assign pp_hh = 8'(in.a[7:4]) * 8'(in.b[7:4]);   // Exact
    assign pp_ll = 8'(in.a[3:0]) * 8'(in.b[3:0]);   // Exact

    mul4x4_split #(
        .SPLIT (`AM_HL_SPLIT),
        .OUT_K (`AM_HL_OUT_K)
    ) i_mul_hl (
        .a (in.a[7:4]),
        .b (in.b[3:0]),
        .p (pp_hl)
    );

    mul4x4_split #(
        .SPLIT (`AM_LH_SPLIT),
        .OUT_K (`AM_LH_OUT_K)
    ) i_mul_lh (
        .a (in.a[3:0]),
        .b (in.b[7:4]),
        .p (pp_lh)
    );

    // ############################################################
    // Handshake
    // ############################################################
    assign s2_adv   = !out_valid || out_ready;
    assign s1_adv   = !s1_valid || s2_adv;
    assign in_ready = s1_adv;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (s1_adv) begin
                s1_valid <= in_valid;
            end
            if (s2_adv) begin
                out_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            s1_hh  <= pp_hh;
            s1_hl  <= pp_hl;
            s1_lh  <= pp_lh;
            s1_ll  <= pp_ll;
            s1_tag <= in.tag;
        end
        if (s1_valid && s2_adv) begin
            out <= s2_next;
        end
    end

    // ############################################################
    // Stage 2 summation
    // ############################################################
    lor_adder #(
        .W (8),
        .K (`AM_TOP_MID_K)
    ) i_mid_add (
        .x   (s1_hl),
        .y   (s1_lh),
        .sum (mid_sum)
    );

    assign fin_x = {s1_hh, s1_ll[7:4]};
    assign fin_y = {3'b000, mid_sum};

    lor_adder #(
        .W (12),
        .K (`AM_TOP_OUT_K)
    ) i_fin_add (
        .x   (fin_x),
        .y   (fin_y),
        .sum (fin_sum)
    );

    always_comb begin
        s2_next.product = {fin_sum[11:0], s1_ll[3:0]};   // Carry out of bit 15 dropped
        s2_next.tag     = s1_tag;
    end

    // Held result may not change while the FIFO refuses it
    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out))
        else $error("mul8x8_approx output changed while stalled");

    // Stage 2 still empty one cycle after reset is released
    a_out_reset: assert property (@(posedge clk) $rose(rst_n) |=> !out_valid)
        else $error("mul8x8_approx out_valid high after reset");

endmodule

/* rtl/mul4x4_split.sv */
`timescale 1ns/1ns

module mul4x4_split #(
    parameter int SPLIT = 2,
    parameter int OUT_K = 0
) (
    input  logic [3:0] a,
    input  logic [3:0] b,
    output logic [7:0] p
);

    localparam int HW   = 4 - SPLIT;       // High part width
    localparam int HH_W = 2 * HW;
    localparam int LL_W = 2 * SPLIT;
    localparam int CR_W = HW + SPLIT;      // Cross products are always 4 bits
    localparam int OP_W = HH_W + SPLIT;    // Second adder width, 8 - SPLIT

    logic [HW-1:0]    a_h, b_h;
    logic [SPLIT-1:0] a_l, b_l;

    logic [HH_W-1:0]  p_hh;
    logic [CR_W-1:0]  p_hl, p_lh;
    logic [LL_W-1:0]  p_ll;

    logic [CR_W:0]    cross_sum;
    logic [OP_W-1:0]  op_hi;
    logic [OP_W-1:0]  op_cross;
    logic [OP_W:0]    out_sum;

    assign a_h = a[3:SPLIT];
    assign b_h = b[3:SPLIT];
    assign a_l = a[SPLIT-1:0];
    assign b_l = b[SPLIT-1:0];

    // ############################################################
    // Exact sub-products
    // ############################################################
    assign p_hh = HH_W'(a_h) * HH_W'(b_h);
    assign p_hl = CR_W'(a_h) * CR_W'(b_l);
    assign p_lh = CR_W'(a_l) * CR_W'(b_h);
    assign p_ll = LL_W'(a_l) * LL_W'(b_l);

    lor_adder #(
        .W (CR_W),
        .K (0)
    ) i_cross_add (
        .x   (p_hl),
        .y   (p_lh),
        .sum (cross_sum)
    );

    assign op_hi    = {p_hh, p_ll[LL_W-1:SPLIT]};
    assign op_cross = OP_W'(cross_sum);

    lor_adder #(
        .W (OP_W),
        .K (OUT_K)
    ) i_out_add (
        .x   (op_hi),
        .y   (op_cross),
        .sum (out_sum)
    );

    // Top carry of the second adder is dropped
    assign p = {out_sum[OP_W-1:0], p_ll[SPLIT-1:0]};

endmodule

/* rtl/lor_adder.sv */
`timescale 1ns/1ns

module lor_adder #(
    parameter int W = 8,
    parameter int K = 0
) (
    input  logic [W-1:0] x,
    input  logic [W-1:0] y,
    output logic [W:0]   sum
);

    localparam int HW = W - K;   // Width of the exact upper part

    logic [HW:0] hi_sum;

    // Upper part, no carry comes in from the OR section
    assign hi_sum = {1'b0, x[W-1:K]} + {1'b0, y[W-1:K]};

    generate
        if (K > 0) begin : g_lor
            assign sum = {hi_sum, x[K-1:0] | y[K-1:0]};
        end else begin : g_exact
            assign sum = hi_sum;
        end
    endgenerate

endmodule

/* rtl/approx_mul_pkg.sv */
`include "approx_mul_config.svh"

package approx_mul_pkg;

    // ############################################################
    // Request and response words
    // ############################################################

    typedef struct packed {
        logic [7:0]           a;
        logic [7:0]           b;
        logic [`AM_TAG_W-1:0] tag;   // Returned unchanged with the result
    } mul_req_t;

    typedef struct packed {
        logic [15:0]          product;
        logic [`AM_TAG_W-1:0] tag;
    } mul_rsp_t;

endpackage

/* rtl/approx_mul_config.svh */
`ifndef APPROX_MUL_CONFIG_SVH
`define APPROX_MUL_CONFIG_SVH

// ############################################################
// Stream and buffer sizing
// ############################################################
`define AM_TAG_W        4
`define AM_FIFO_DEPTH   4

// ############################################################
// Approximation levels
// ############################################################
`define AM_HL_SPLIT     3   // High x low nibble block, low part width
`define AM_LH_SPLIT     2   // Low x high nibble block, low part width
`define AM_HL_OUT_K     0
`define AM_LH_OUT_K     1
`define AM_TOP_MID_K    0   // Cross term adder of the 8x8
`define AM_TOP_OUT_K    3   // Final 12 bit adder of the 8x8

`endif
